// ==== rtl/decodePkg.sv ====
// ISA widths and decode types for the 16-bit core; opcodes 00010 and 00011 are left unassigned
package decodePkg;

   localparam int wordW    = 16;   // data and instruction width
   localparam int regAddrW = 3;    // register address width
   localparam int numRegs  = 8;    // r0..r7, r7 is the link register
   localparam int opW      = 5;    // opcode field, instr[15:11]
   localparam int aluOpW   = 4;

   // opcode field encodings
   typedef enum logic [opW-1:0] {
      opHalt  = 5'b00000,
      opNop   = 5'b00001,
      opJ     = 5'b00100,
      opJr    = 5'b00101,
      opJal   = 5'b00110,
      opJalr  = 5'b00111,
      opAddi  = 5'b01000,
      opSubi  = 5'b01001,
      opXori  = 5'b01010,
      opAndni = 5'b01011,
      opBeqz  = 5'b01100,
      opBnez  = 5'b01101,
      opBltz  = 5'b01110,
      opBgez  = 5'b01111,
      opSt    = 5'b10000,
      opLd    = 5'b10001,
      opSlbi  = 5'b10010,
      opStu   = 5'b10011,
      opRoli  = 5'b10100,
      opSlli  = 5'b10101,
      opRori  = 5'b10110,
      opSrli  = 5'b10111,
      opLbi   = 5'b11000,
      opBtr   = 5'b11001,
      opShfr  = 5'b11010,   // rol/sll/ror/srl by instr[1:0]
      opAlur  = 5'b11011,   // add/sub/xor/andn by instr[1:0]
      opSeq   = 5'b11100,
      opSlt   = 5'b11101,
      opSle   = 5'b11110,
      opSco   = 5'b11111
   } opcode_e;

   // operation handed to the execute stage
   typedef enum logic [aluOpW-1:0] {
      aluAdd   = 4'd0,
      aluSub   = 4'd1,
      aluXor   = 4'd2,
      aluAndn  = 4'd3,
      aluRol   = 4'd4,
      aluSll   = 4'd5,
      aluRor   = 4'd6,
      aluSrl   = 4'd7,
      aluSeq   = 4'd8,
      aluSlt   = 4'd9,
      aluSle   = 4'd10,
      aluSco   = 4'd11,
      aluBtr   = 4'd12,
      aluPassB = 4'd13,
      aluSlbi  = 4'd14    // (a << 8) | b
   } aluOp_e;

   typedef enum logic [1:0] {bReg, bImm5, bImm8, bImm11} bSrc_e;

   // dstF10 = instr[10:8], dstF7 = instr[7:5], dstF4 = instr[4:2]
   typedef enum logic [1:0] {dstF10, dstF7, dstF4, dstR7} regDst_e;

   typedef enum logic [1:0] {wbAlu, wbMem, wbPc2, wbSet} wbSel_e;

   typedef struct packed {
      logic       aluJmp;    // jump target comes from the ALU (JR, JALR)
      logic       memWrt;
      logic       readEn;    // memory read, follows wbSel == wbMem
      logic       regWrt;
      logic [2:0] brchSig;   // {isBranch, cond}, cond = opcode[1:0]
      logic       cin;
      logic       invA;
      logic       invB;
      wbSel_e     wbSel;
      bSrc_e      bSrc;
      regDst_e    regDst;
      logic       zeroSel;   // zero-extend imm5/imm8
      logic       stuSel;    // store data taken from the second source register
      logic       immSrc;    // pc offset is imm11 rather than imm8
      logic       jalSel;    // link write of pc+2
      logic       halt;
   } ctrl_t;

   // write port from the writeback stage
   typedef struct packed {
      logic                en;
      logic [regAddrW-1:0] addr;
      logic [wordW-1:0]    data;
   } wbPort_t;

   // ID/EX bundle
   typedef struct packed {
      logic                valid;
      logic                err;       // illegal opcode, only meaningful with valid
      ctrl_t               ctrl;
      aluOp_e              aluOp;
      logic [wordW-1:0]    inA;
      logic [wordW-1:0]    inB;
      logic [wordW-1:0]    wrtData;
      logic [wordW-1:0]    imm8;
      logic [wordW-1:0]    imm11;
      logic [regAddrW-1:0] wrtReg;
   } decOut_t;

endpackage

// ==== rtl/controlUnit.sv ====
// purely combinational; unassigned opcodes give an all-inactive ctrl with ctrlErr high
`timescale 1ns/100ps
module controlUnit (
   input  logic [decodePkg::wordW-1:0] instr,
   output decodePkg::ctrl_t            ctrl,
   output logic                        ctrlErr
);
   import decodePkg::*;

   opcode_e    opcode;
   logic [1:0] func;   // function bits for ALUR

   assign opcode = opcode_e'(instr[wordW-1 -: opW]);
   assign func   = instr[1:0];

   always_comb begin
      ctrl    = '0;   // wbAlu, bReg, dstF10, no branch
      ctrlErr = 1'b0;
      case (opcode)
         opHalt: ctrl.halt = 1'b1;
         opNop: ctrl.halt = 1'b0;   // bubble, nothing asserted

         // immediate arithmetic, logic and shifts: Rd in 7..5
         opAddi, opSubi, opXori, opAndni, opRoli, opSlli, opRori, opSrli: begin
            ctrl.regWrt  = 1'b1;
            ctrl.bSrc    = bImm5;
            ctrl.regDst  = dstF7;
            ctrl.invA    = (opcode == opSubi);   // imm - Rs
            ctrl.cin     = (opcode == opSubi);
            ctrl.zeroSel = (opcode == opXori) || (opcode == opAndni);
         end

         opSt: begin
            ctrl.memWrt = 1'b1;
            ctrl.bSrc   = bImm5;   // address = Rs + imm5
            ctrl.stuSel = 1'b1;    // store data is Rd from 7..5
         end
         opLd: begin
            ctrl.regWrt = 1'b1;
            ctrl.bSrc   = bImm5;
            ctrl.wbSel  = wbMem;
            ctrl.regDst = dstF7;
         end
         opStu: begin
            ctrl.memWrt = 1'b1;
            ctrl.regWrt = 1'b1;    // Rs gets the effective address
            ctrl.bSrc   = bImm5;
            ctrl.stuSel = 1'b1;
            ctrl.regDst = dstF10;
         end

         // register-register forms, Rd in 4..2
         opAlur: begin
            ctrl.regWrt = 1'b1;
            ctrl.regDst = dstF4;
            ctrl.invA   = (func == 2'b01);   // sub is Rt - Rs
            ctrl.cin    = (func == 2'b01);
         end
         opShfr, opBtr: begin
            ctrl.regWrt = 1'b1;
            ctrl.regDst = dstF4;
         end
         opSeq, opSlt, opSle: begin
            ctrl.regWrt = 1'b1;
            ctrl.regDst = dstF4;
            ctrl.wbSel  = wbSet;
            ctrl.invB   = 1'b1;   // Rs - Rt
            ctrl.cin    = 1'b1;
         end
         opSco: begin
            ctrl.regWrt = 1'b1;
            ctrl.regDst = dstF4;
            ctrl.wbSel  = wbSet;   // carry out of Rs + Rt
         end

         opBeqz, opBnez, opBltz, opBgez: begin
            ctrl.brchSig = {1'b1, instr[12:11]};
            ctrl.bSrc    = bImm8;   // pc offset
         end

         opLbi, opSlbi: begin
            ctrl.regWrt  = 1'b1;
            ctrl.bSrc    = bImm8;
            ctrl.regDst  = dstF10;
            ctrl.zeroSel = (opcode == opSlbi);
         end

         opJ: begin
            ctrl.immSrc = 1'b1;
            ctrl.bSrc   = bImm11;
         end
         opJal: begin
            ctrl.immSrc = 1'b1;
            ctrl.bSrc   = bImm11;
            ctrl.regWrt = 1'b1;
            ctrl.jalSel = 1'b1;
            ctrl.wbSel  = wbPc2;
            ctrl.regDst = dstR7;
         end
         opJr: begin
            ctrl.aluJmp = 1'b1;   // target = Rs + imm8
            ctrl.bSrc   = bImm8;
         end
         opJalr: begin
            ctrl.aluJmp = 1'b1;
            ctrl.bSrc   = bImm8;
            ctrl.regWrt = 1'b1;
            ctrl.jalSel = 1'b1;
            ctrl.wbSel  = wbPc2;
            ctrl.regDst = dstR7;
         end

         default: begin
            ctrl    = '0;
            ctrlErr = 1'b1;   // unassigned opcode
         end
      endcase
      ctrl.readEn = (ctrl.wbSel == wbMem);

      // only STU both writes memory and updates a register
      assert final (!(ctrl.regWrt && ctrl.memWrt) || opcode == opStu)
         else $error("regWrt and memWrt both set for opcode %b", opcode);
   end

endmodule

// ==== rtl/aluOpDecode.sv ====
// combinational; unassigned opcodes fall through to add, ctrlErr flags them elsewhere
`timescale 1ns/100ps
module aluOpDecode (
   input  logic [decodePkg::wordW-1:0] instr,
   output decodePkg::aluOp_e           aluOp
);
   import decodePkg::*;

   opcode_e    opcode;
   logic [1:0] func;

   assign opcode = opcode_e'(instr[wordW-1 -: opW]);
   assign func   = instr[1:0];

   always_comb begin
      case (opcode)
         opSubi: aluOp = aluSub;
         opXori: aluOp = aluXor;
         opAndni: aluOp = aluAndn;
         opRoli: aluOp = aluRol;
         opSlli: aluOp = aluSll;
         opRori: aluOp = aluRor;
         opSrli: aluOp = aluSrl;
         opAlur: begin
            case (func)
               2'b00: aluOp = aluAdd;
               2'b01: aluOp = aluSub;
               2'b10: aluOp = aluXor;
               default: aluOp = aluAndn;
            endcase
         end
         opShfr: begin
            case (func)
               2'b00: aluOp = aluRol;
               2'b01: aluOp = aluSll;
               2'b10: aluOp = aluRor;
               default: aluOp = aluSrl;
            endcase
         end
         opSeq: aluOp = aluSeq;
         opSlt: aluOp = aluSlt;
         opSle: aluOp = aluSle;
         opSco: aluOp = aluSco;
         opBtr: aluOp = aluBtr;
         opBeqz, opBnez, opBltz, opBgez: aluOp = aluSub;   // compare Rs against zero
         opLbi: aluOp = aluPassB;
         opSlbi: aluOp = aluSlbi;
         default: aluOp = aluAdd;   // ADDI, LD, ST, STU, jumps, HALT, NOP
      endcase
   end

endmodule

// ==== rtl/immGen.sv ====
// combinational; imm11 ignores zeroSel and is always sign-extended
`timescale 1ns/100ps
module immGen (
   input  logic [decodePkg::wordW-1:0] instr,
   input  logic                        zeroSel,
   output logic [decodePkg::wordW-1:0] imm5,
   output logic [decodePkg::wordW-1:0] imm8,
   output logic [decodePkg::wordW-1:0] imm11
);
   import decodePkg::*;

   localparam int w5  = 5;
   localparam int w8  = 8;
   localparam int w11 = 11;

   logic fill5;   // upper fill bit for imm5
   logic fill8;

   // zero fill for XORI, ANDNI, SLBI
   assign fill5 = zeroSel ? 1'b0 : instr[w5-1];
   assign fill8 = zeroSel ? 1'b0 : instr[w8-1];

   assign imm5  = {{(wordW-w5){fill5}}, instr[w5-1:0]};
   assign imm8  = {{(wordW-w8){fill8}}, instr[w8-1:0]};
   assign imm11 = {{(wordW-w11){instr[w11-1]}}, instr[w11-1:0]};   // J, JAL offset

endmodule

// ==== rtl/regFile.sv ====
// no write-to-read bypass; a write shows on the read ports only after its clock edge
`timescale 1ns/100ps
module regFile (
   input  logic                           clk,
   input  logic                           arstN,
   input  logic [decodePkg::regAddrW-1:0] rdAddrA,
   input  logic [decodePkg::regAddrW-1:0] rdAddrB,
   output logic [decodePkg::wordW-1:0]    rdA,
   output logic [decodePkg::wordW-1:0]    rdB,
   input  decodePkg::wbPort_t             wb
);
   import decodePkg::*;

   logic [wordW-1:0] regs [numRegs];   // r0 is an ordinary register

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         for (int i = 0; i < numRegs; i++) begin
            regs[i] <= '0;
         end
      end else if (wb.en) begin
         regs[wb.addr] <= wb.data;   // also written while the stage stalls
      end
   end

   assign rdA = regs[rdAddrA];   // Rs, instr[10:8]
   assign rdB = regs[rdAddrB];   // Rt, instr[7:5]

   // a write with an unknown address would corrupt an unknown register
   wbAddrKnown: assert property (
      @(posedge clk) disable iff (!arstN)
      wb.en |-> !$isunknown(wb.addr)
   ) else $error("register write with unknown address %b", wb.addr);

endmodule

// ==== rtl/operandSel.sv ====
// combinational; stuSel takes store data from Rt for both ST and STU
`timescale 1ns/100ps
module operandSel (
   input  logic [decodePkg::wordW-1:0]    instr,
   input  logic [decodePkg::wordW-1:0]    rdB,
   input  logic [decodePkg::wordW-1:0]    imm5,
   input  logic [decodePkg::wordW-1:0]    imm8,
   input  logic [decodePkg::wordW-1:0]    imm11,
   input  decodePkg::bSrc_e               bSrc,
   input  decodePkg::regDst_e             regDst,
   input  logic                           stuSel,
   output logic [decodePkg::wordW-1:0]    inB,
   output logic [decodePkg::wordW-1:0]    wrtData,
   output logic [decodePkg::regAddrW-1:0] wrtReg
);
   import decodePkg::*;

   // ALU B operand
   always_comb begin
      case (bSrc)
         bImm5: inB = imm5;
         bImm8: inB = imm8;
         bImm11: inB = imm11;
         default: inB = rdB;   // bReg
      endcase
   end

   assign wrtData = stuSel ? rdB : inB;   // memory write data

   // destination register
   always_comb begin
      case (regDst)
         dstF10: wrtReg = instr[10:8];   // STU, LBI, SLBI
         dstF7: wrtReg = instr[7:5];     // I-format
         dstF4: wrtReg = instr[4:2];     // R-format
         default: wrtReg = regAddrW'(numRegs - 1);   // r7 link for JAL, JALR
      endcase
   end

endmodule

// ==== rtl/decodeStage.sv ====
// upstream must hold instr and instrValid while stall is high; no hazard or forwarding logic
`timescale 1ns/100ps
module decodeStage (
   input  logic                        clk,
   input  logic                        arstN,
   input  logic [decodePkg::wordW-1:0] instr,
   input  logic                        instrValid,
   input  logic                        stall,
   input  decodePkg::wbPort_t          wb,
   output decodePkg::decOut_t          decOut
);
   import decodePkg::*;

   ctrl_t               ctrl;
   logic                ctrlErr;
   aluOp_e              aluOp;
   logic [wordW-1:0]    imm5;
   logic [wordW-1:0]    imm8;
   logic [wordW-1:0]    imm11;
   logic [wordW-1:0]    rdA;
   logic [wordW-1:0]    rdB;
   logic [wordW-1:0]    inB;
   logic [wordW-1:0]    wrtData;
   logic [regAddrW-1:0] wrtReg;
   decOut_t             decNext;   // ID/EX input

   controlUnit u_controlUnit (.instr(instr), .ctrl(ctrl), .ctrlErr(ctrlErr));

   aluOpDecode u_aluOpDecode (.instr(instr), .aluOp(aluOp));

   immGen u_immGen (
      .instr(instr), .zeroSel(ctrl.zeroSel), .imm5(imm5), .imm8(imm8), .imm11(imm11)
   );

   regFile u_regFile (
      .clk(clk), .arstN(arstN), .rdAddrA(instr[10:8]), .rdAddrB(instr[7:5]),
      .rdA(rdA), .rdB(rdB), .wb(wb)
   );

   operandSel u_operandSel (
      .instr(instr), .rdB(rdB), .imm5(imm5), .imm8(imm8), .imm11(imm11),
      .bSrc(ctrl.bSrc), .regDst(ctrl.regDst), .stuSel(ctrl.stuSel),
      .inB(inB), .wrtData(wrtData), .wrtReg(wrtReg)
   );

   always_comb begin
      decNext.valid   = instrValid;
      decNext.err     = ctrlErr;
      decNext.ctrl    = ctrl;
      decNext.aluOp   = aluOp;
      decNext.inA     = rdA;
      decNext.inB     = inB;
      decNext.wrtData = wrtData;
      decNext.imm8    = imm8;    // branch offset for the pc adder
      decNext.imm11   = imm11;   // jump offset
      decNext.wrtReg  = wrtReg;
   end

   // ID/EX register, holds while stalled
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) decOut <= '0;
      else if (!stall) decOut <= decNext;
   end

   // the execute stage sees a frozen bundle for every stalled cycle
   stallHold: assert property (
      @(posedge clk) disable iff (!arstN)
      stall |=> $stable(decOut)
   ) else $error("decOut changed during stall");

endmodule

// ==== test/decodeChecker.sv ====
// compares decOut one rising edge after each pushed instruction; stalled edges are skipped
`timescale 1ns/100ps
module decodeChecker (
   input  logic               clk,
   input  logic               arstN,
   input  logic               stall,
   input  decodePkg::decOut_t decOut
);
   import decodePkg::*;

   decOut_t expQ[$];    // expected bundles in issue order
   decOut_t expCur;
   decOut_t prevOut;    // decOut seen at the previous falling edge
   logic    loaded;     // an instruction was taken at the last rising edge
   logic    stalled;    // the last rising edge was stalled
   logic    started;
   int      errCount;

   initial begin
      loaded   = 1'b0;
      stalled  = 1'b0;
      started  = 1'b0;
      errCount = 0;
      prevOut  = '0;
   end

   task automatic push(input decOut_t exp);
      expQ.push_back(exp);
   endtask

   task automatic compareField(input string name, input logic [15:0] exp, input logic [15:0] got);
      if (exp !== got) begin
         $display("Mismatch at %0t ns: %s expected %h got %h", $time, name, exp, got);
         errCount++;
      end
   endtask

   // stall and the queue only change at falling edges
   always @(posedge clk) begin
      stalled = arstN && stall;
      loaded  = 1'b0;
      if (arstN && !stall && expQ.size() > 0) begin
         expCur  = expQ.pop_front();
         loaded  = 1'b1;
         started = 1'b1;
      end
   end

   always @(negedge clk) begin
      // reset value and the bubbles that follow it
      if (!started && {decOut.valid, decOut.ctrl.regWrt,
                       decOut.ctrl.memWrt, decOut.ctrl.halt} !== 4'b0000) begin
         $display("Mismatch at %0t ns: decOut active before the first instruction", $time);
         errCount++;
      end
      if (stalled && decOut !== prevOut) begin
         $display("Mismatch at %0t ns: decOut changed during stall", $time);
         errCount++;
      end
      if (loaded) begin
         compareField("valid", 16'(expCur.valid), 16'(decOut.valid));
         compareField("err", 16'(expCur.err), 16'(decOut.err));
         compareField("aluOp", 16'(expCur.aluOp), 16'(decOut.aluOp));
         compareField("wbSel", 16'(expCur.ctrl.wbSel), 16'(decOut.ctrl.wbSel));
         compareField("regWrt", 16'(expCur.ctrl.regWrt), 16'(decOut.ctrl.regWrt));
         compareField("memWrt", 16'(expCur.ctrl.memWrt), 16'(decOut.ctrl.memWrt));
         compareField("halt", 16'(expCur.ctrl.halt), 16'(decOut.ctrl.halt));
         compareField("bSrc", 16'(expCur.ctrl.bSrc), 16'(decOut.ctrl.bSrc));
         compareField("zeroSel", 16'(expCur.ctrl.zeroSel), 16'(decOut.ctrl.zeroSel));
         compareField("regDst", 16'(expCur.ctrl.regDst), 16'(decOut.ctrl.regDst));
         compareField("stuSel", 16'(expCur.ctrl.stuSel), 16'(decOut.ctrl.stuSel));
         compareField("inA", expCur.inA, decOut.inA);
         compareField("inB", expCur.inB, decOut.inB);
         compareField("wrtData", expCur.wrtData, decOut.wrtData);
         compareField("imm8", expCur.imm8, decOut.imm8);
         compareField("imm11", expCur.imm11, decOut.imm11);
         compareField("wrtReg", 16'(expCur.wrtReg), 16'(decOut.wrtReg));
      end
      prevOut = decOut;
   end

endmodule

// ==== test/decodeStageTb.sv ====
// drives on falling edges; expected operands come from a model copy of the register file
`timescale 1ns/100ps
module decodeStageTb;
   import decodePkg::*;

   localparam time clkPer = 40ns;

   typedef struct packed {
      logic [wordW-1:0] instr;
      aluOp_e           aluOp;
      wbSel_e           wbSel;
      logic             regWrt;
      logic             memWrt;
      logic             err;
      bSrc_e            bSrc;
      logic             zext;     // imm5/imm8 zero-extended
      regDst_e          regDst;
      logic             stuSel;   // store data from Rt
   } row_t;

   logic             clk;
   logic             arstN;
   logic [wordW-1:0] instr;
   logic             instrValid;
   logic             stall;
   wbPort_t          wb;
   decOut_t          decOut;

   row_t             rows[$];
   logic [wordW-1:0] model [numRegs];
   logic [31:0]      rngState;
   int               otherErrs;
   row_t             addRow;

   decodeStage u_decodeStage (.clk(clk), .arstN(arstN), .instr(instr), .instrValid(instrValid),
                              .stall(stall), .wb(wb), .decOut(decOut));

   decodeChecker u_checker (.clk(clk), .arstN(arstN), .stall(stall), .decOut(decOut));

   initial begin
      clk = 1'b0;
      forever #(clkPer / 2) clk = ~clk;
   end

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic addEntry(input logic [15:0] i, input aluOp_e op, input wbSel_e ws,
                           input logic rw, input logic mw, input logic er, input bSrc_e bs,
                           input logic z, input regDst_e rd, input logic st);
      rows.push_back('{i, op, ws, rw, mw, er, bs, z, rd, st});
   endtask

   // expected bundle from the ISA rules and the model registers
   function automatic decOut_t expectFor(input row_t r);
      decOut_t          e;
      logic [wordW-1:0] i5;
      logic [wordW-1:0] i8;
      logic [wordW-1:0] rt;
      e  = '0;
      rt = model[r.instr[7:5]];
      i5 = r.zext ? {11'b0, r.instr[4:0]} : {{11{r.instr[4]}}, r.instr[4:0]};
      i8 = r.zext ? {8'b0, r.instr[7:0]} : {{8{r.instr[7]}}, r.instr[7:0]};
      e.valid        = 1'b1;
      e.err          = r.err;
      e.aluOp        = r.aluOp;
      e.ctrl.wbSel   = r.wbSel;
      e.ctrl.regWrt  = r.regWrt;
      e.ctrl.memWrt  = r.memWrt;
      e.ctrl.halt    = (r.instr[15:11] == 5'b00000);
      e.ctrl.bSrc    = r.bSrc;
      e.ctrl.zeroSel = r.zext;
      e.ctrl.regDst  = r.regDst;
      e.ctrl.stuSel  = r.stuSel;
      e.inA          = model[r.instr[10:8]];
      e.imm8         = i8;
      e.imm11        = {{5{r.instr[10]}}, r.instr[10:0]};
      case (r.bSrc)
         bImm5: e.inB = i5;
         bImm8: e.inB = i8;
         bImm11: e.inB = e.imm11;
         default: e.inB = rt;
      endcase
      e.wrtData = r.stuSel ? rt : e.inB;
      case (r.regDst)
         dstF7: e.wrtReg = r.instr[7:5];
         dstF4: e.wrtReg = r.instr[4:2];
         dstR7: e.wrtReg = 3'd7;
         default: e.wrtReg = r.instr[10:8];
      endcase
      return e;
   endfunction

   task automatic issue(input row_t r);
      @(negedge clk);
      instr      = r.instr;
      instrValid = 1'b1;
      u_checker.push(expectFor(r));
   endtask

   initial begin
      // watchdog sized from the table, the preload and some margin
      #1;
      #((rows.size() + numRegs + 20) * clkPer);
      $display("watchdog expired before the test sequence finished");
      $display("Simulation FAILED");
      $finish;
   end

   initial begin
      arstN      = 1'b0;
      instr      = {5'b00001, 11'h000};   // NOP bubble until the first row
      instrValid = 1'b0;
      stall      = 1'b0;
      wb         = '0;
      otherErrs = 0;
      rngState  = 32'h6ef0_c82c;
      addEntry({5'b01000, 3'd1, 3'd2, 5'b11101}, aluAdd, wbAlu, 1, 0, 0, bImm5, 0, dstF7, 0);
      addEntry({5'b01001, 3'd3, 3'd4, 5'b00111}, aluSub, wbAlu, 1, 0, 0, bImm5, 0, dstF7, 0);
      addEntry({5'b01010, 3'd5, 3'd6, 5'b10110}, aluXor, wbAlu, 1, 0, 0, bImm5, 1, dstF7, 0);
      addEntry({5'b01011, 3'd7, 3'd0, 5'b11111}, aluAndn, wbAlu, 1, 0, 0, bImm5, 1, dstF7, 0);
      addEntry({5'b10100, 3'd2, 3'd3, 5'b00011}, aluRol, wbAlu, 1, 0, 0, bImm5, 0, dstF7, 0);
      addEntry({5'b10111, 3'd4, 3'd5, 5'b10001}, aluSrl, wbAlu, 1, 0, 0, bImm5, 0, dstF7, 0);
      addEntry({5'b10000, 3'd1, 3'd3, 5'b10010}, aluAdd, wbAlu, 0, 1, 0, bImm5, 0, dstF10, 1);
      addEntry({5'b10001, 3'd2, 3'd6, 5'b01010}, aluAdd, wbMem, 1, 0, 0, bImm5, 0, dstF7, 0);
      addEntry({5'b10011, 3'd6, 3'd7, 5'b11000}, aluAdd, wbAlu, 1, 1, 0, bImm5, 0, dstF10, 1);
      addEntry({5'b11011, 3'd1, 3'd2, 3'd5, 2'b00}, aluAdd, wbAlu, 1, 0, 0, bReg, 0, dstF4, 0);
      addEntry({5'b11011, 3'd3, 3'd4, 3'd6, 2'b01}, aluSub, wbAlu, 1, 0, 0, bReg, 0, dstF4, 0);
      addEntry({5'b11011, 3'd5, 3'd0, 3'd1, 2'b11}, aluAndn, wbAlu, 1, 0, 0, bReg, 0, dstF4, 0);
      addEntry({5'b11010, 3'd6, 3'd7, 3'd2, 2'b10}, aluRor, wbAlu, 1, 0, 0, bReg, 0, dstF4, 0);
      addEntry({5'b11001, 3'd2, 3'd0, 3'd3, 2'b00}, aluBtr, wbAlu, 1, 0, 0, bReg, 0, dstF4, 0);
      addEntry({5'b11100, 3'd4, 3'd5, 3'd7, 2'b00}, aluSeq, wbSet, 1, 0, 0, bReg, 0, dstF4, 0);
      addEntry({5'b11111, 3'd0, 3'd1, 3'd2, 2'b00}, aluSco, wbSet, 1, 0, 0, bReg, 0, dstF4, 0);
      addEntry({5'b01100, 3'd3, 8'hF0}, aluSub, wbAlu, 0, 0, 0, bImm8, 0, dstF10, 0);
      addEntry({5'b01111, 3'd5, 8'h12}, aluSub, wbAlu, 0, 0, 0, bImm8, 0, dstF10, 0);
      addEntry({5'b11000, 3'd4, 8'h9C}, aluPassB, wbAlu, 1, 0, 0, bImm8, 0, dstF10, 0);
      addEntry({5'b10010, 3'd2, 8'hA5}, aluSlbi, wbAlu, 1, 0, 0, bImm8, 1, dstF10, 0);
      addEntry({5'b00100, 11'h5F3}, aluAdd, wbAlu, 0, 0, 0, bImm11, 0, dstF10, 0);
      addEntry({5'b00110, 11'h20C}, aluAdd, wbPc2, 1, 0, 0, bImm11, 0, dstR7, 0);
      addEntry({5'b00111, 3'd3, 8'h81}, aluAdd, wbPc2, 1, 0, 0, bImm8, 0, dstR7, 0);
      addEntry({5'b00000, 11'h000}, aluAdd, wbAlu, 0, 0, 0, bReg, 0, dstF10, 0);
      addEntry({5'b00010, 11'h123}, aluAdd, wbAlu, 0, 0, 1, bReg, 0, dstF10, 0);   // illegal
      addEntry({5'b00001, 11'h000}, aluAdd, wbAlu, 0, 0, 0, bReg, 0, dstF10, 0);
      for (int i = 0; i < numRegs; i++) begin
         model[i] = '0;
      end

      repeat (4) @(negedge clk);
      arstN = 1'b1;
      @(negedge clk);

      // preload every register through the writeback port
      for (int i = 0; i < numRegs; i++) begin
         @(negedge clk);
         rngState = xorshift(rngState);
         wb       = '{1'b1, regAddrW'(i), rngState[wordW-1:0]};
         model[i] = rngState[wordW-1:0];
      end
      @(negedge clk);
      wb = '0;

      foreach (rows[n]) begin
         issue(rows[n]);
      end

      // write r1 on the same edge that samples an instruction reading r1
      addRow = rows[9];
      issue(addRow);
      issue(addRow);   // sampled on the edge of the r1 write, still old r1
      rngState = xorshift(rngState);
      wb       = '{1'b1, 3'd1, rngState[wordW-1:0]};
      model[1] = rngState[wordW-1:0];
      issue(addRow);   // new r1
      wb       = '0;

      // hold stall for three cycles and expect the held instruction one cycle after it falls
      issue(rows[1]);
      stall = 1'b1;
      repeat (3) @(negedge clk);
      stall = 1'b0;
      @(negedge clk);
      instrValid = 1'b0;
      repeat (3) @(negedge clk);

      if (u_checker.expQ.size() != 0) begin
         $display("%0d expected results were never compared", u_checker.expQ.size());
         otherErrs++;
      end
      $display("errors: %0d mismatches, %0d other", u_checker.errCount, otherErrs);
      if (u_checker.errCount == 0 && otherErrs == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

// ==== vlog.f ====
rtl/decodePkg.sv
rtl/controlUnit.sv
rtl/aluOpDecode.sv
rtl/immGen.sv
rtl/regFile.sv
rtl/operandSel.sv
rtl/decodeStage.sv
test/decodeChecker.sv
test/decodeStageTb.sv
